// ==== bench/correlator_tb.sv ====
// Cross correlator testbench
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;
	import corr_config_pkg::*;
	import corr_stream_pkg::*;

	// Control word, one frame of samples, then header and payload
	localparam int record_words = 1 + integration_length + 1 + payload_length;
	localparam int num_records = 4;
	localparam int timeout_cycles = 200;

	logic pllclk;
	logic reset;
	logic sample_valid;
	complex_sample samples [num_lines];
	line_control controls [num_lines];
	logic credit_return;
	frame_beat beat_out;

	logic [31:0] vectors [num_records * record_words];
	logic [15:0] lfsr_state;
	frame_beat got [$];
	int owed;
	int record_base;
	logic [31:0] next_header;

	correlator_top UUT (
		.pllclk(pllclk),
		.reset(reset),
		.sample_valid(sample_valid),
		.samples(samples),
		.controls(controls),
		.credit_return(credit_return),
		.beat_out(beat_out)
	);

	initial pllclk = 1'b0;
	always #10 pllclk = ~pllclk;

	// 16 bit Fibonacci LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic reset_dut(input int rec);
		record_base = rec * record_words;
		reset = 1'b0;
		sample_valid = 1'b0;
		credit_return = 1'b0;
		for (int l = 0; l < num_lines; l++) begin
			samples[l] = '0;
			controls[l] = vectors[record_base][l*4 +: 4];
		end
		got.delete();
		owed = 0;
		repeat (10) @(posedge pllclk);
		#2;
		reset = 1'b1;
	endtask

	// Drives strobes and credits, collects beats
	task automatic run_cycles(input string name, input int strobes, input int wanted,
			input bit give_credits, input int min_cycles);
		int sent;
		int cycles;
		int idle;
		int idx;
		bit done;
		sent = 0;
		cycles = 0;
		idle = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge pllclk);
			#2;
			sample_valid = 1'b0;
			credit_return = 1'b0;
			cycles++;
			idle++;
			if (beat_out.valid) begin
				got.push_back(beat_out);
				owed++;
				idle = 0;
			end
			if (sent >= strobes && got.size() >= wanted && cycles >= min_cycles) begin
				done = 1'b1;
			end else if (idle > timeout_cycles) begin
				abort_run($sformatf("no beat received before timeout in %s", name));
			end else begin
				if (sent < strobes && lfsr_bit()) begin
					idx = sent % integration_length;
					for (int l = 0; l < num_lines; l++) begin
						samples[l] = vectors[record_base + 1 + idx][l*4 +: 4];
					end
					sample_valid = 1'b1;
					sent++;
					idle = 0;
				end
				if (give_credits && owed > 0 && lfsr_bit()) begin
					credit_return = 1'b1;
					owed--;
				end
			end
		end
	endtask

	// Primed frames carry the lag 0 value in all three lags
	task automatic check_frame(input string name, input int first,
			input logic [31:0] header_word, input bit primed);
		frame_beat beat;
		logic [31:0] expected;
		int bl;
		int payload_base;
		payload_base = record_base + 1 + integration_length;
		check_value({name, " beats received"}, first + payload_length + 1, got.size());
		for (int j = 0; j <= payload_length; j++) begin
			beat = got[first + j];
			bl = (j - 1) / num_lags;
			if (j == 0) begin
				expected = header_word;
			end else if (primed) begin
				expected = vectors[payload_base + 1 + bl * num_lags + 1];
			end else begin
				expected = vectors[payload_base + j];
			end
			check_value($sformatf("%s beat %0d header", name, j), 32'(j == 0),
				32'(beat.header));
			check_value($sformatf("%s beat %0d last", name, j),
				32'(j == payload_length), 32'(beat.last));
			check_value($sformatf("%s beat %0d word", name, j), expected, beat.word);
		end
	endtask

	task automatic run_basic(input int rec, input string name);
		reset_dut(rec);
		run_cycles(name, integration_length, payload_length + 1, 1'b1, 0);
		check_frame(name, 0, vectors[record_base + 1 + integration_length], 1'b0);
	endtask

	initial begin
		lfsr_state = 16'd20;
		$readmemh("bench/correlator_vectors.txt", vectors);

		run_basic(0, "constant");
		run_basic(1, "impulse");
		run_basic(2, "disabled line");
		run_basic(3, "large product");

		// No credits returned until the sender stalls
		reset_dut(0);
		run_cycles("backpressure", integration_length, credit_max, 1'b0, 0);
		run_cycles("backpressure", 0, credit_max, 1'b0, 30);
		check_value("backpressure stalled beats", credit_max, got.size());
		run_cycles("backpressure", 0, payload_length + 1, 1'b1, 0);
		check_frame("backpressure", 0, vectors[record_base + 1 + integration_length], 1'b0);

		// Second dump lands while the first frame is still held
		reset_dut(0);
		run_cycles("frame drop", 2 * integration_length, credit_max, 1'b0, 0);
		run_cycles("frame drop", 0, credit_max, 1'b0, 10);
		check_value("frame drop stalled beats", credit_max, got.size());
		run_cycles("frame drop", 0, payload_length + 1, 1'b1, 0);
		check_frame("frame drop first", 0, vectors[record_base + 1 + integration_length], 1'b0);
		next_header = vectors[record_base + 1 + integration_length];
		next_header[31:16] = next_header[31:16] + 16'd1;
		next_header[15:8] = 8'd1;
		run_cycles("frame drop", integration_length, 2 * (payload_length + 1), 1'b1, 0);
		check_frame("frame drop next", payload_length + 1, next_header, 1'b1);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/correlator_vectors.txt ====
// Record: control word (line 3 down to 0, enable and delay), 32 sample words
// (line 3 down to 0, i and q), header word, 18 payload words {re, im}
// Constant samples, zero delay, all lines enabled
8888
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
00000012 001F001F 00200020 001F001F 0000FFC2 0000FFC0 0000FFC2
FFE1001F FFE00020 FFE1001F FFE1FFE1 FFE0FFE0 FFE1FFE1
0000001F 00000020 0000001F FFE1FFE1 FFE0FFE0 FFE1FFE1
// Impulse on line 0 against line 1 delayed by two
FDA8
0010 0014 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010
00000012 0000FFFF 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
// Line 2 disabled
8088
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
3D45 3D45 3D45 3D45 3D45 3D45 3D45 3D45
00000012 001F001F 00200020 001F001F 00000000 00000000 00000000
FFE1001F FFE00020 FFE1001F 00000000 00000000 00000000
0000001F 00000020 0000001F 00000000 00000000 00000000
// Largest products, real 8 and imaginary 6
8888
96AA 96AA 96AA 96AA 96AA 96AA 96AA 96AA
96AA 96AA 96AA 96AA 96AA 96AA 96AA 96AA
96AA 96AA 96AA 96AA 96AA 96AA 96AA 96AA
96AA 96AA 96AA 96AA 96AA 96AA 96AA 96AA
00000012 00F80000 01000000 00F80000 003EFF46 0040FF40 003EFF46
003E00BA 004000C0 003E00BA 003EFF46 0040FF40 003EFF46
003E00BA 004000C0 003E00BA FF84005D FF800060 FF84005D

// ==== list.f ====
verilog/corr_config_pkg.sv
verilog/corr_stream_pkg.sv
verilog/sample_delay_line.sv
verilog/baseline_mac.sv
verilog/integration_control.sv
verilog/frame_sender.sv
verilog/correlator_top.sv
bench/correlator_tb.sv

// ==== verilog/baseline_mac.sv ====
// Baseline multiply accumulate
`timescale 1ns/1ps
`default_nettype none

module baseline_mac (
	input logic pllclk,
	input logic reset,
	input logic step,
	input logic dump,
	input corr_config_pkg::complex_sample line_a_near,
	input corr_config_pkg::complex_sample line_a_far,
	input corr_config_pkg::complex_sample line_b_near,
	input corr_config_pkg::complex_sample line_b_far,
	output corr_config_pkg::corr_value snapshot [corr_config_pkg::num_lags]
);
	import corr_config_pkg::*;

	complex_sample x_op [num_lags];
	complex_sample y_op [num_lags];
	logic signed [product_width-1:0] prod_re [num_lags];
	logic signed [product_width-1:0] prod_im [num_lags];
	corr_value acc [num_lags];
	corr_value acc_next [num_lags];

	// Lag -1 uses the older a sample, lag +1 the older b sample
	assign x_op[0] = line_a_far;
	assign y_op[0] = line_b_near;
	assign x_op[1] = line_a_near;
	assign y_op[1] = line_b_near;
	assign x_op[2] = line_a_near;
	assign y_op[2] = line_b_far;

	function automatic logic signed [acc_width-1:0] sat_add(
		input logic signed [acc_width-1:0] acc_in,
		input logic signed [product_width-1:0] inc
	);
		logic signed [acc_width:0] sum;
		sum = acc_in + inc;
		if (sum > acc_max) begin
			return acc_width'(acc_max);
		end else if (sum < -acc_max) begin
			return acc_width'(-acc_max);
		end
		return sum[acc_width-1:0];
	endfunction

	always_comb begin
		for (int l = 0; l < num_lags; l++) begin
			// x times conj(y)
			prod_re[l] = $signed(x_op[l].i) * $signed(y_op[l].i)
				+ $signed(x_op[l].q) * $signed(y_op[l].q);
			prod_im[l] = $signed(x_op[l].q) * $signed(y_op[l].i)
				- $signed(x_op[l].i) * $signed(y_op[l].q);
			if (step) begin
				acc_next[l].re = sat_add(acc[l].re, prod_re[l]);
				acc_next[l].im = sat_add(acc[l].im, prod_im[l]);
			end else begin
				acc_next[l] = acc[l];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int l = 0; l < num_lags; l++) begin
				acc[l] <= '0;
				snapshot[l] <= '0;
			end
		end else begin
			for (int l = 0; l < num_lags; l++) begin
				if (dump) begin
					// Final step of the frame lands in the snapshot
					snapshot[l] <= acc_next[l];
					acc[l] <= '0;
				end else begin
					acc[l] <= acc_next[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/corr_config_pkg.sv ====
// Correlator configuration types
`default_nettype none

package corr_config_pkg;

	// Array geometry
	localparam int num_lines = 4;
	localparam int num_baselines = num_lines * (num_lines - 1) / 2;
	localparam int num_lags = 3;
	localparam int num_values = num_baselines * num_lags;

	// Delay line taps
	localparam int delay_depth = 8;
	localparam int delay_width = $clog2(delay_depth);

	// One conjugate product term spans -6 to 8
	localparam int product_width = 5;

	localparam int acc_width = 16;
	localparam int acc_max = 2 ** (acc_width - 1) - 1;

	localparam int integration_length = 32;
	localparam int count_width = $clog2(integration_length);

	// Line pair of each baseline
	localparam int baseline_line_a [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int baseline_line_b [num_baselines] = '{1, 2, 3, 2, 3, 3};

	typedef struct packed {
		logic signed [1:0] i;
		logic signed [1:0] q;
	} complex_sample;

	typedef struct packed {
		logic enable;
		logic [delay_width-1:0] delay;
	} line_control;

	typedef struct packed {
		logic signed [acc_width-1:0] re;
		logic signed [acc_width-1:0] im;
	} corr_value;

endpackage

`default_nettype wire

// ==== verilog/corr_stream_pkg.sv ====
// Frame stream types
`default_nettype none

package corr_stream_pkg;

	// Credits held by the sender after reset
	localparam int credit_max = 4;
	localparam int credit_width = $clog2(credit_max + 1);

	// One payload beat per lag of each baseline
	localparam int payload_length = corr_config_pkg::num_values;
	localparam int beat_index_width = $clog2(payload_length + 1);

	typedef struct packed {
		logic [15:0] frame_number;
		logic [7:0] dropped_frames;
		logic [7:0] payload_beats;
	} frame_header;

	// The header flag tells a header beat from a correlation value
	typedef union packed {
		frame_header header;
		corr_config_pkg::corr_value value;
	} beat_word;

	typedef struct packed {
		logic valid;
		logic header;
		logic last;
		beat_word word;
	} frame_beat;

endpackage

`default_nettype wire

// ==== verilog/correlator_top.sv ====
// Four line cross correlator
`timescale 1ns/1ps
`default_nettype none

module correlator_top (
	input logic pllclk,
	input logic reset,
	input logic sample_valid,
	input corr_config_pkg::complex_sample samples [corr_config_pkg::num_lines],
	input corr_config_pkg::line_control controls [corr_config_pkg::num_lines],
	input logic credit_return,
	output corr_stream_pkg::frame_beat beat_out
);
	import corr_config_pkg::*;

	complex_sample tap_near [num_lines];
	complex_sample tap_far [num_lines];
	corr_value snapshots [num_baselines][num_lags];
	corr_value frame_values [num_values];
	logic step;
	logic dump;

	integration_control u_control (
		.pllclk(pllclk),
		.reset(reset),
		.sample_valid(sample_valid),
		.step(step),
		.dump(dump)
	);

	for (genvar line = 0; line < num_lines; line++) begin : g_line
		sample_delay_line u_delay (
			.pllclk(pllclk),
			.reset(reset),
			.sample_valid(sample_valid),
			.sample(samples[line]),
			.control(controls[line]),
			.tap_near(tap_near[line]),
			.tap_far(tap_far[line])
		);
	end

	for (genvar bl = 0; bl < num_baselines; bl++) begin : g_baseline
		baseline_mac u_mac (
			.pllclk(pllclk),
			.reset(reset),
			.step(step),
			.dump(dump),
			.line_a_near(tap_near[baseline_line_a[bl]]),
			.line_a_far(tap_far[baseline_line_a[bl]]),
			.line_b_near(tap_near[baseline_line_b[bl]]),
			.line_b_far(tap_far[baseline_line_b[bl]]),
			.snapshot(snapshots[bl])
		);
		// Payload runs by baseline, then lag
		for (genvar lag = 0; lag < num_lags; lag++) begin : g_lag
			assign frame_values[bl * num_lags + lag] = snapshots[bl][lag];
		end
	end

	frame_sender u_sender (
		.pllclk(pllclk),
		.reset(reset),
		.dump(dump),
		.frame_values(frame_values),
		.credit_return(credit_return),
		.beat_out(beat_out)
	);

endmodule

`default_nettype wire

// ==== verilog/frame_sender.sv ====
// Credit based frame sender
`timescale 1ns/1ps
`default_nettype none

module frame_sender (
	input logic pllclk,
	input logic reset,
	input logic dump,
	input corr_config_pkg::corr_value frame_values [corr_config_pkg::num_values],
	input logic credit_return,
	output corr_stream_pkg::frame_beat beat_out
);
	import corr_config_pkg::*;
	import corr_stream_pkg::*;

	corr_value held [num_values];
	logic held_full;
	logic frame_ready;
	logic [beat_index_width-1:0] beat_index;
	logic [15:0] frame_number;
	logic [7:0] drop_count;
	logic [credit_width-1:0] credits;
	logic send;
	logic send_header;
	logic send_last;
	logic take;
	logic drop_event;
	logic beat_valid;
	logic beat_header;
	logic beat_last;
	beat_word beat_data;
	frame_header header_now;

	assign send = held_full && (credits != '0);
	assign send_header = send && (beat_index == '0);
	assign send_last = send && (beat_index == beat_index_width'(payload_length));
	// Snapshots hold the finished frame one cycle after dump
	assign take = frame_ready && !held_full;
	assign drop_event = frame_ready && held_full;

	assign header_now = '{
		frame_number: frame_number,
		dropped_frames: drop_count,
		payload_beats: 8'(payload_length)
	};

	assign beat_out = '{
		valid: beat_valid,
		header: beat_header,
		last: beat_last,
		word: beat_data
	};

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			held_full <= 1'b0;
			frame_ready <= 1'b0;
			beat_index <= '0;
			frame_number <= '0;
			drop_count <= '0;
			credits <= credit_width'(credit_max);
			beat_valid <= 1'b0;
		end else begin
			frame_ready <= dump;
			beat_valid <= send;
			if (take) begin
				held_full <= 1'b1;
			end else if (send_last) begin
				held_full <= 1'b0;
			end
			if (send) begin
				beat_index <= send_last ? '0 : beat_index + 1'b1;
			end
			if (send_last) begin
				frame_number <= frame_number + 1'b1;
			end
			// Drops are reported once, in the next header sent
			if (send_header) begin
				drop_count <= drop_event ? 8'd1 : 8'd0;
			end else if (drop_event && drop_count != '1) begin
				drop_count <= drop_count + 1'b1;
			end
			unique case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					if (credits != credit_width'(credit_max)) begin
						credits <= credits + 1'b1;
					end
				end
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (take) begin
			for (int k = 0; k < num_values; k++) begin
				held[k] <= frame_values[k];
			end
		end
		if (send) begin
			beat_header <= send_header;
			beat_last <= send_last;
			if (send_header) begin
				beat_data.header <= header_now;
			end else begin
				beat_data.value <= held[beat_index - 1'b1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/integration_control.sv ====
// Integration period control
`timescale 1ns/1ps
`default_nettype none

module integration_control (
	input logic pllclk,
	input logic reset,
	input logic sample_valid,
	output logic step,
	output logic dump
);
	import corr_config_pkg::*;

	logic [count_width-1:0] sample_count;
	logic last_sample;

	// Strobe that closes the integration period
	assign last_sample = sample_valid
		&& (sample_count == count_width'(integration_length - 1));

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			step <= 1'b0;
			dump <= 1'b0;
			sample_count <= '0;
		end else begin
			// Step lines up with the delay line taps
			step <= sample_valid;
			// Dump rises together with the last step
			dump <= last_sample;
			if (sample_valid) begin
				if (last_sample) begin
					sample_count <= '0;
				end else begin
					sample_count <= sample_count + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sample_delay_line.sv ====
// Complex sample delay line
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line (
	input logic pllclk,
	input logic reset,
	input logic sample_valid,
	input corr_config_pkg::complex_sample sample,
	input corr_config_pkg::line_control control,
	output corr_config_pkg::complex_sample tap_near,
	output corr_config_pkg::complex_sample tap_far
);
	import corr_config_pkg::*;

	// history[0] is one strobe old
	complex_sample history [delay_depth];
	complex_sample window [delay_depth + 1];

	// Incoming sample ahead of the stored ones gives taps 0 to 8
	always_comb begin
		window[0] = sample;
		for (int k = 0; k < delay_depth; k++) begin
			window[k + 1] = history[k];
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int k = 0; k < delay_depth; k++) begin
				history[k] <= '0;
			end
			tap_near <= '0;
			tap_far <= '0;
		end else if (sample_valid) begin
			for (int k = 0; k < delay_depth; k++) begin
				history[k] <= window[k];
			end
			if (control.enable) begin
				tap_near <= window[control.delay];
				tap_far <= window[control.delay + 1];
			end else begin
				// Disabled line feeds zeros
				tap_near <= '0;
				tap_far <= '0;
			end
		end
	end

endmodule

`default_nettype wire
